//--- Bender.yml
package:
  name: ooo_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/core_pkg.sv
      - hdl/register_file.sv
      - hdl/wb_slave_port.sv
      - hdl/instr_decode.sv
      - hdl/exec_units.sv
      - hdl/reorder_buffer.sv
      - hdl/ooo_core.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/clk_gen.sv
      - bench/commit_checker.sv
      - bench/tb_ooo_core.sv

//--- bench/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
  output logic clk_o,
  output logic rst_o
);
  initial begin
    clk_o = 1'b0;
    rst_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b1;
  end

  // 20 ns period
  always #10 clk_o = ~clk_o;

endmodule

//--- bench/commit_checker.sv
`timescale 1ns/100ps
`include "core_macros.svh"

module commit_checker (
  input  logic              clk_i,
  input  logic              rst_i,
  input  core_pkg::commit_t commit_i,
  output int                error_count_o,
  output int                commit_count_o,
  output int                pending_o
);
  logic [`REG_ADDR_W+`XLEN-1:0] exp_q [$];
  logic [`REG_ADDR_W+`XLEN-1:0] exp_entry;
  string                        test_name = "none";
  int                           errors = 0;
  int                           commits = 0;
  int                           pending = 0;

  assign error_count_o  = errors;
  assign commit_count_o = commits;
  assign pending_o      = pending;

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic push_expected(input logic [`REG_ADDR_W-1:0] rd, input logic [`XLEN-1:0] data);
    exp_q.push_back({rd, data});
    pending++;
  endtask

  task automatic report_leftover();
    logic [`REG_ADDR_W+`XLEN-1:0] e;
    while (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      pending--;
      errors++;
      $display("leftover in %s: x%0d = 0x%08h was expected but never committed",
               test_name, e[`XLEN +: `REG_ADDR_W], e[`XLEN-1:0]);
    end
  endtask

  // Register readback against the reference model
  task automatic compare_reg(input int idx, input logic [`XLEN-1:0] exp_val,
                             input logic [`XLEN-1:0] act_val);
    if (act_val !== exp_val) begin
      errors++;
      $display("mismatch %s: x%0d expected 0x%08h, actual 0x%08h",
               test_name, idx, exp_val, act_val);
    end
  endtask

  // Commit port is registered and sampled at the rising edge
  always @(posedge clk_i) begin
    if (rst_i && commit_i.valid) begin
      commits++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected commit in %s: x%0d = 0x%08h with nothing expected",
                 test_name, commit_i.rd, commit_i.data);
      end else begin
        exp_entry = exp_q.pop_front();
        pending--;
        if (exp_entry !== {commit_i.rd, commit_i.data}) begin
          errors++;
          $display("mismatch %s: expected x%0d = 0x%08h, actual x%0d = 0x%08h",
                   test_name, exp_entry[`XLEN +: `REG_ADDR_W], exp_entry[`XLEN-1:0],
                   commit_i.rd, commit_i.data);
        end
      end
    end
  end

endmodule

//--- bench/tb_ooo_core.sv
`timescale 1ns/100ps
`include "core_macros.svh"

module tb_ooo_core;
  localparam int NUM_TESTS = 6;
  localparam int MAX_WORDS = 64;
  localparam int DRAIN_CYCLES = 100;

  logic                   clk, rst;
  logic                   wb_cyc, wb_stb, wb_we, wb_ack;
  logic [`REG_ADDR_W-1:0] wb_adr;
  logic [`XLEN-1:0]       wb_dat_w, wb_dat_r;
  core_pkg::commit_t      commit;
  int                     error_count, commit_count, pending;

  // Stimulus table with one run of words per test
  string            test_names [NUM_TESTS];
  int               test_first [NUM_TESTS];
  int               test_len   [NUM_TESTS];
  logic [`XLEN-1:0] prog       [MAX_WORDS];
  int               total_words = 0;
  int               cur_test = 0;
  logic             table_ready = 1'b0;

  logic [`XLEN-1:0] ref_regs [`NUM_REGS];
  logic [31:0]      rng_state = 32'd23808;
  int               tests_failed = 0;

  clk_gen i_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  ooo_core i_ooo_core (
    .clk_i    (clk),
    .rst_i    (rst),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack),
    .commit_o (commit)
  );

  commit_checker i_commit_checker (
    .clk_i          (clk),
    .rst_i          (rst),
    .commit_i       (commit),
    .error_count_o  (error_count),
    .commit_count_o (commit_count),
    .pending_o      (pending)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [`XLEN-1:0] encode_op(input logic [3:0] op,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    logic [`XLEN-1:0] w;
    w = '0;
    w[`OPCODE_MSB:`OPCODE_LSB]  = op;
    w[`RD_LSB +: `REG_ADDR_W]  = rd;
    w[`RS1_LSB +: `REG_ADDR_W] = rs1;
    w[`RS2_LSB +: `REG_ADDR_W] = rs2;
    return w;
  endfunction

  function automatic logic [`XLEN-1:0] li_word(input logic [4:0] rd, input logic [15:0] imm);
    logic [`XLEN-1:0] w;
    w = encode_op(core_pkg::OP_LI, rd, 5'd0, 5'd0);
    w[`IMM_W-1:0] = imm;
    return w;
  endfunction

  task automatic start_test(input int idx, input string name);
    test_names[idx] = name;
    test_first[idx] = total_words;
    test_len[idx]   = 0;
    cur_test        = idx;
  endtask

  task automatic add_word(input logic [`XLEN-1:0] w);
    prog[total_words] = w;
    total_words++;
    test_len[cur_test]++;
  endtask

  function automatic logic [15:0] next_imm();
    rng_state = xorshift(rng_state);
    return rng_state[15:0];
  endfunction

  // ==========================================================
  // Test table
  // ==========================================================
  task automatic build_table();
    start_test(0, "alu_ops");
    add_word(li_word(5'd1, 16'h1234));
    add_word(li_word(5'd2, 16'hf0f0));
    add_word(encode_op(core_pkg::OP_ADD, 5'd3, 5'd1, 5'd2));
    add_word(encode_op(core_pkg::OP_SUB, 5'd4, 5'd1, 5'd2));
    add_word(encode_op(core_pkg::OP_AND, 5'd5, 5'd1, 5'd2));
    add_word(encode_op(core_pkg::OP_OR,  5'd6, 5'd1, 5'd2));
    add_word(encode_op(core_pkg::OP_XOR, 5'd7, 5'd1, 5'd2));
    start_test(1, "mul_then_alu");
    add_word(li_word(5'd8, 16'd300));
    add_word(encode_op(core_pkg::OP_MUL, 5'd9,  5'd8, 5'd1));
    add_word(encode_op(core_pkg::OP_ADD, 5'd10, 5'd1, 5'd1));
    add_word(encode_op(core_pkg::OP_XOR, 5'd11, 5'd2, 5'd1));
    add_word(encode_op(core_pkg::OP_OR,  5'd12, 5'd1, 5'd8));
    start_test(2, "raw_chain_x0");
    add_word(encode_op(core_pkg::OP_MUL, 5'd13, 5'd8,  5'd2));
    add_word(encode_op(core_pkg::OP_ADD, 5'd14, 5'd13, 5'd1));
    add_word(encode_op(core_pkg::OP_MUL, 5'd15, 5'd14, 5'd13));
    add_word(encode_op(core_pkg::OP_ADD, 5'd0,  5'd1,  5'd2));
    start_test(3, "mul_burst");
    // More multiplies than reorder buffer entries
    for (int i = 0; i < 12; i++) begin
      add_word(encode_op(core_pkg::OP_MUL, 5'(16 + i), 5'(1 + i), 5'(2 + i)));
    end
    start_test(4, "undefined_op");
    add_word(li_word(5'd28, 16'd77));
    add_word(encode_op(4'hf, 5'd29, 5'd1, 5'd2));
    add_word(encode_op(core_pkg::OP_ADD, 5'd29, 5'd28, 5'd1));
    add_word(encode_op(4'h0, 5'd30, 5'd1, 5'd2));
    add_word(encode_op(core_pkg::OP_SUB, 5'd30, 5'd29, 5'd28));
    start_test(5, "random_imm");
    add_word(li_word(5'd31, next_imm()));
    add_word(li_word(5'd1, next_imm()));
    add_word(encode_op(core_pkg::OP_XOR, 5'd2, 5'd31, 5'd1));
    add_word(encode_op(core_pkg::OP_MUL, 5'd3, 5'd31, 5'd2));
    add_word(encode_op(core_pkg::OP_ADD, 5'd4, 5'd3,  5'd1));
    add_word(li_word(5'd5, next_imm()));
  endtask

  // Reference model fed in program order
  task automatic model_step(input logic [`XLEN-1:0] w);
    logic [3:0]       op;
    logic [4:0]       rd;
    logic [`XLEN-1:0] a, b, res;
    logic             known;
    op    = w[`OPCODE_MSB:`OPCODE_LSB];
    rd    = w[`RD_LSB +: `REG_ADDR_W];
    a     = ref_regs[w[`RS1_LSB +: `REG_ADDR_W]];
    b     = ref_regs[w[`RS2_LSB +: `REG_ADDR_W]];
    known = 1'b1;
    res   = '0;
    case (op)
      core_pkg::OP_ADD: res = a + b;
      core_pkg::OP_SUB: res = a - b;
      core_pkg::OP_AND: res = a & b;
      core_pkg::OP_OR:  res = a | b;
      core_pkg::OP_XOR: res = a ^ b;
      core_pkg::OP_LI:  res = {16'h0000, w[15:0]};
      core_pkg::OP_MUL: res = a * b;
      default:          known = 1'b0;
    endcase
    if (known && rd != 5'd0) begin
      ref_regs[rd] = res;
      i_commit_checker.push_expected(rd, res);
    end
  endtask

  task automatic push_instr(input logic [`XLEN-1:0] w);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = '0;
    wb_dat_w = w;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk);
  endtask

  task automatic read_reg(input logic [4:0] idx, output logic [`XLEN-1:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = idx;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    @(negedge clk);
  endtask

  // Wait for the expected queue to empty, then flag what never committed
  task automatic drain_core();
    int waited;
    waited = 0;
    while (pending != 0 && waited < DRAIN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    i_commit_checker.report_leftover();
    @(negedge clk);
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin : stimulus
    logic [`XLEN-1:0] rd_val;
    int               errs_before;
    int               commits_before;
    int               total_errors;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    for (int r = 0; r < `NUM_REGS; r++) begin
      ref_regs[r] = '0;
    end
    build_table();
    table_ready = 1'b1;
    wait (rst === 1'b1);
    @(negedge clk);

    for (int t = 0; t < NUM_TESTS; t++) begin
      errs_before    = error_count;
      commits_before = commit_count;
      i_commit_checker.set_test(test_names[t]);
      for (int k = 0; k < test_len[t]; k++) begin
        model_step(prog[test_first[t] + k]);
        push_instr(prog[test_first[t] + k]);
      end
      drain_core();
      if (error_count != errs_before) begin
        tests_failed++;
      end
      $display("test %s: %0d words, %0d commits, %0d errors", test_names[t], test_len[t],
               commit_count - commits_before, error_count - errs_before);
    end

    // Architectural state after the core is drained
    errs_before = error_count;
    i_commit_checker.set_test("readback");
    for (int r = 0; r < `NUM_REGS; r++) begin
      read_reg(5'(r), rd_val);
      i_commit_checker.compare_reg(r, ref_regs[r], rd_val);
    end
    @(negedge clk);
    if (error_count != errs_before) begin
      tests_failed++;
    end
    $display("test readback: %0d registers, %0d errors", `NUM_REGS, error_count - errs_before);

    total_errors = error_count;
    $display("summary: %0d tests, %0d failed, %0d commits, %0d errors",
             NUM_TESTS + 1, tests_failed, commit_count, total_errors);
    if (total_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int limit_ns;
    wait (table_ready === 1'b1);
    limit_ns = total_words * 40 * 20 + 2000;
    #(limit_ns);
    $display("timeout: run did not finish within %0d ns, %0d commits still expected",
             limit_ns, pending);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- hdl/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data path and register file
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// Reorder buffer and multiply pipeline
`define ROB_DEPTH   8
`define ROB_TAG_W   3
`define MUL_LATENCY 5

// Instruction word fields
`define OPCODE_MSB  31
`define OPCODE_LSB  28
`define RD_LSB      23
`define RS1_LSB     18
`define RS2_LSB     13
`define IMM_W       16

`endif

//--- hdl/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

  typedef enum logic [3:0] {
    OP_ADD = 4'd1,
    OP_SUB = 4'd2,
    OP_AND = 4'd3,
    OP_OR  = 4'd4,
    OP_XOR = 4'd5,
    OP_LI  = 4'd6,
    OP_MUL = 4'd7
  } opcode_e;

  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_MUL = 1'b1
  } exec_unit_e;

  // One-word instruction buffer
  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  word;
  } instr_slot_t;

  typedef struct packed {
    logic                   valid;
    exec_unit_e             unit;
    opcode_e                opcode;
    logic [`XLEN-1:0]       op_a;
    logic [`XLEN-1:0]       op_b;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`ROB_TAG_W-1:0]  tag;
  } issue_t;

  typedef struct packed {
    logic                   valid;
    logic [`ROB_TAG_W-1:0]  tag;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } result_t;

  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } commit_t;

endpackage

//--- hdl/exec_units.sv
`timescale 1ns/100ps
`include "core_macros.svh"

module exec_units (
  input  logic              clk_i,
  input  logic              rst_i,
  input  core_pkg::issue_t  issue_i,
  output core_pkg::result_t result_o
);
  core_pkg::result_t alu_q;
  core_pkg::result_t mul_q [`MUL_LATENCY];
  logic [`XLEN-1:0]  alu_res;

  always_comb begin
    case (issue_i.opcode)
      core_pkg::OP_ADD: alu_res = issue_i.op_a + issue_i.op_b;
      core_pkg::OP_SUB: alu_res = issue_i.op_a - issue_i.op_b;
      core_pkg::OP_AND: alu_res = issue_i.op_a & issue_i.op_b;
      core_pkg::OP_OR:  alu_res = issue_i.op_a | issue_i.op_b;
      core_pkg::OP_XOR: alu_res = issue_i.op_a ^ issue_i.op_b;
      core_pkg::OP_LI:  alu_res = issue_i.op_b;
      default:          alu_res = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    alu_q.tag       <= issue_i.tag;
    alu_q.rd        <= issue_i.rd;
    alu_q.data      <= alu_res;
    // Product formed in the first stage, then carried along
    mul_q[0].tag    <= issue_i.tag;
    mul_q[0].rd     <= issue_i.rd;
    mul_q[0].data   <= issue_i.op_a * issue_i.op_b;
    for (int s = 1; s < `MUL_LATENCY; s++) begin
      mul_q[s] <= mul_q[s-1];
    end
    if (!rst_i) begin
      alu_q.valid <= 1'b0;
      for (int s = 0; s < `MUL_LATENCY; s++) begin
        mul_q[s].valid <= 1'b0;
      end
    end else begin
      alu_q.valid    <= issue_i.valid && issue_i.unit == core_pkg::UNIT_ALU;
      mul_q[0].valid <= issue_i.valid && issue_i.unit == core_pkg::UNIT_MUL;
    end
  end

  assign result_o = alu_q.valid ? alu_q : mul_q[`MUL_LATENCY-1];

  no_result_clash: assert property (@(posedge clk_i) disable iff (!rst_i)
    !(alu_q.valid && mul_q[`MUL_LATENCY-1].valid));

endmodule

//--- hdl/instr_decode.sv
`timescale 1ns/100ps
`include "core_macros.svh"

module instr_decode (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  core_pkg::instr_slot_t  slot_i,
  output logic                   take_o,
  output logic [`REG_ADDR_W-1:0] rs1_addr_o,
  output logic [`REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [`XLEN-1:0]       rs1_data_i,
  input  logic [`XLEN-1:0]       rs2_data_i,
  input  logic                   rob_full_i,
  input  logic [`ROB_TAG_W-1:0]  rob_tag_i,
  output logic                   alloc_o,
  output logic [`REG_ADDR_W-1:0] alloc_rd_o,
  input  core_pkg::result_t      result_i,
  output core_pkg::issue_t       issue_o
);
  core_pkg::opcode_e          opcode;
  core_pkg::exec_unit_e       unit;
  logic                       defined;
  logic [`REG_ADDR_W-1:0]     rd;
  logic [`XLEN-1:0]           imm;
  logic [`NUM_REGS-1:0]       pending_q;
  logic [`MUL_LATENCY-1:0]    resv_q;
  logic                       raw, waw, slot_clash, stall, go;

  assign opcode     = core_pkg::opcode_e'(slot_i.word[`OPCODE_MSB:`OPCODE_LSB]);
  assign rd         = slot_i.word[`RD_LSB +: `REG_ADDR_W];
  assign rs1_addr_o = slot_i.word[`RS1_LSB +: `REG_ADDR_W];
  assign rs2_addr_o = slot_i.word[`RS2_LSB +: `REG_ADDR_W];
  assign imm        = {{(`XLEN-`IMM_W){1'b0}}, slot_i.word[`IMM_W-1:0]};

  always_comb begin
    defined = 1'b1;
    unit    = core_pkg::UNIT_ALU;
    case (opcode)
      core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND,
      core_pkg::OP_OR, core_pkg::OP_XOR, core_pkg::OP_LI: unit = core_pkg::UNIT_ALU;
      core_pkg::OP_MUL: unit = core_pkg::UNIT_MUL;
      default: defined = 1'b0;
    endcase
  end

  // ==========================================================
  // Hazards
  // ==========================================================
  // LI has no source operands
  assign raw = opcode != core_pkg::OP_LI &&
               (pending_q[rs1_addr_o] || pending_q[rs2_addr_o]);
  assign waw = pending_q[rd];
  // resv_q[1] is the result bus cycle an ALU op issued now would use
  assign slot_clash = unit == core_pkg::UNIT_ALU && resv_q[1];
  assign stall  = defined && (raw || waw || rob_full_i || slot_clash);
  assign go     = slot_i.valid && defined && !stall;
  assign take_o = slot_i.valid && !stall;

  assign alloc_o    = go;
  assign alloc_rd_o = rd;

  always_ff @(posedge clk_i) begin
    issue_o.unit   <= unit;
    issue_o.opcode <= opcode;
    issue_o.op_a   <= rs1_data_i;
    issue_o.op_b   <= (opcode == core_pkg::OP_LI) ? imm : rs2_data_i;
    issue_o.rd     <= rd;
    issue_o.tag    <= rob_tag_i;
    if (!rst_i) begin
      issue_o.valid <= 1'b0;
      pending_q     <= '0;
      resv_q        <= '0;
    end else begin
      issue_o.valid <= go;
      resv_q        <= {go && unit == core_pkg::UNIT_MUL, resv_q[`MUL_LATENCY-1:1]};
      if (result_i.valid) begin
        pending_q[result_i.rd] <= 1'b0;
      end
      if (go && rd != '0) begin
        pending_q[rd] <= 1'b1;
      end
    end
  end

  result_was_pending: assert property (@(posedge clk_i) disable iff (!rst_i)
    result_i.valid && result_i.rd != '0 |-> pending_q[result_i.rd]);

endmodule

//--- hdl/ooo_core.sv
`timescale 1ns/100ps
`include "core_macros.svh"

module ooo_core (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [`REG_ADDR_W-1:0] wb_adr_i,
  input  logic [`XLEN-1:0]       wb_dat_i,
  output logic [`XLEN-1:0]       wb_dat_o,
  output logic                   wb_ack_o,
  output core_pkg::commit_t      commit_o
);
  core_pkg::instr_slot_t  slot;
  core_pkg::issue_t       issue;
  core_pkg::result_t      result;
  logic                   take;
  logic [`REG_ADDR_W-1:0] rs1_addr, rs2_addr, arch_rd_addr, alloc_rd;
  logic [`XLEN-1:0]       rs1_data, rs2_data, arch_rd_data;
  logic [`ROB_TAG_W-1:0]  rob_tag;
  logic                   rob_full, alloc;

  // ==========================================================
  // Front end
  // ==========================================================
  wb_slave_port i_wb_slave_port (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .take_i         (take),
    .slot_o         (slot),
    .arch_rd_addr_o (arch_rd_addr),
    .arch_rd_data_i (arch_rd_data)
  );

  instr_decode i_instr_decode (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .slot_i     (slot),
    .take_o     (take),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rob_full_i (rob_full),
    .rob_tag_i  (rob_tag),
    .alloc_o    (alloc),
    .alloc_rd_o (alloc_rd),
    .result_i   (result),
    .issue_o    (issue)
  );

  // Speculative values, written out of order
  register_file future_file (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wr_en_i     (result.valid),
    .wr_addr_i   (result.rd),
    .wr_data_i   (result.data),
    .rd_addr_a_i (rs1_addr),
    .rd_addr_b_i (rs2_addr),
    .rd_data_a_o (rs1_data),
    .rd_data_b_o (rs2_data)
  );

  // ==========================================================
  // Execute and retire
  // ==========================================================
  exec_units i_exec_units (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .issue_i  (issue),
    .result_o (result)
  );

  reorder_buffer i_reorder_buffer (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .alloc_i    (alloc),
    .alloc_rd_i (alloc_rd),
    .tag_o      (rob_tag),
    .full_o     (rob_full),
    .result_i   (result),
    .commit_o   (commit_o)
  );

  register_file arch_file (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wr_en_i     (commit_o.valid),
    .wr_addr_i   (commit_o.rd),
    .wr_data_i   (commit_o.data),
    .rd_addr_a_i (arch_rd_addr),
    .rd_addr_b_i ('0),
    .rd_data_a_o (arch_rd_data),
    .rd_data_b_o ()
  );

endmodule

//--- hdl/register_file.sv
`timescale 1ns/100ps
`include "core_macros.svh"

module register_file (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   wr_en_i,
  input  logic [`REG_ADDR_W-1:0] wr_addr_i,
  input  logic [`XLEN-1:0]       wr_data_i,
  input  logic [`REG_ADDR_W-1:0] rd_addr_a_i,
  input  logic [`REG_ADDR_W-1:0] rd_addr_b_i,
  output logic [`XLEN-1:0]       rd_data_a_o,
  output logic [`XLEN-1:0]       rd_data_b_o
);
  logic [`XLEN-1:0] regs_q [`NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && wr_addr_i != '0) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  // x0 reads as zero
  assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs_q[rd_addr_a_i];
  assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs_q[rd_addr_b_i];

endmodule

//--- hdl/reorder_buffer.sv
`timescale 1ns/100ps
`include "core_macros.svh"

module reorder_buffer (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   alloc_i,
  input  logic [`REG_ADDR_W-1:0] alloc_rd_i,
  output logic [`ROB_TAG_W-1:0]  tag_o,
  output logic                   full_o,
  input  core_pkg::result_t      result_i,
  output core_pkg::commit_t      commit_o
);
  logic [`ROB_DEPTH-1:0]  done_q;
  logic [`REG_ADDR_W-1:0] rd_q   [`ROB_DEPTH];
  logic [`XLEN-1:0]       data_q [`ROB_DEPTH];
  logic [`ROB_TAG_W-1:0]  head_q, tail_q;
  logic [`ROB_TAG_W:0]    count_q;
  logic [`ROB_TAG_W-1:0]  rel_tag;
  logic                   pop;

  assign tag_o  = tail_q;
  assign full_o = count_q == (`ROB_TAG_W+1)'(`ROB_DEPTH);
  assign pop    = count_q != '0 && done_q[head_q];

  // Position of the completing entry relative to the head
  assign rel_tag = result_i.tag - head_q;

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (result_i.valid) begin
      data_q[result_i.tag] <= result_i.data;
    end
    commit_o.rd   <= rd_q[head_q];
    commit_o.data <= data_q[head_q];
    if (!rst_i) begin
      done_q         <= '0;
      head_q         <= '0;
      tail_q         <= '0;
      count_q        <= '0;
      commit_o.valid <= 1'b0;
    end else begin
      if (alloc_i) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      if (result_i.valid) begin
        done_q[result_i.tag] <= 1'b1;
      end
      if (pop) begin
        done_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end
      count_q <= count_q + alloc_i - pop;
      // x0 writes retire silently
      commit_o.valid <= pop && rd_q[head_q] != '0;
    end
  end

  complete_allocated: assert property (@(posedge clk_i) disable iff (!rst_i)
    result_i.valid |-> ({1'b0, rel_tag} < count_q));

endmodule

//--- hdl/wb_slave_port.sv
`timescale 1ns/100ps
`include "core_macros.svh"

module wb_slave_port (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [`REG_ADDR_W-1:0] wb_adr_i,
  input  logic [`XLEN-1:0]       wb_dat_i,
  output logic [`XLEN-1:0]       wb_dat_o,
  output logic                   wb_ack_o,
  input  logic                   take_i,
  output core_pkg::instr_slot_t  slot_o,
  output logic [`REG_ADDR_W-1:0] arch_rd_addr_o,
  input  logic [`XLEN-1:0]       arch_rd_data_i
);
  core_pkg::instr_slot_t slot_q;
  logic                  ack_q;
  logic [`XLEN-1:0]      dat_q;
  logic                  req, rd_req, push, wr_other;

  assign req      = wb_cyc_i && wb_stb_i && !ack_q;
  assign rd_req   = req && !wb_we_i;
  // Instruction push waits for an empty buffer
  assign push     = req && wb_we_i && wb_adr_i == '0 && !slot_q.valid;
  assign wr_other = req && wb_we_i && wb_adr_i != '0;

  always_ff @(posedge clk_i) begin
    if (push) begin
      slot_q.word <= wb_dat_i;
    end
    if (rd_req) begin
      dat_q <= arch_rd_data_i;
    end
    if (!rst_i) begin
      slot_q.valid <= 1'b0;
      ack_q        <= 1'b0;
    end else begin
      slot_q.valid <= push || (slot_q.valid && !take_i);
      ack_q        <= rd_req || push || wr_other;
    end
  end

  assign slot_o         = slot_q;
  assign arch_rd_addr_o = wb_adr_i;
  assign wb_dat_o       = dat_q;
  assign wb_ack_o       = ack_q;

  take_needs_slot: assert property (@(posedge clk_i) disable iff (!rst_i)
    take_i |-> slot_q.valid);

endmodule

//--- project.f
+incdir+hdl
hdl/core_pkg.sv
hdl/register_file.sv
hdl/wb_slave_port.sv
hdl/instr_decode.sv
hdl/exec_units.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
bench/clk_gen.sv
bench/commit_checker.sv
bench/tb_ooo_core.sv
